// ==== project.f ====
+incdir+.
cpu4_pkg.sv
micro_sequencer.sv
regs.sv
alu.sv
cpu4_datapath.sv
tb_checker.sv
tb_cpu4_datapath.sv

// ==== Makefile ====
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := tb_cpu4_datapath
FILELIST   := project.f
PASS_MSG   := TEST RESULT: PASS
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_cpu4_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu4_defs.svh"

module tb_cpu4_datapath;
  import cpu4_pkg::*;

  localparam int UOP_COUNT   = 24 + 38 + 22 + 18 + 80 + 8;
  localparam int CYCLE_LIMIT = 4 * UOP_COUNT + 100;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    issue;
  reg_type                 src;
  reg_type                 dst;
  reg_inc_type             inc;
  alu_op_type              alu_op;
  logic [`CPU4_IMM_W-1:0]  immed;
  logic [`CPU4_DATA_W-1:0] memory_read_data;
  logic [`CPU4_ADDR_W-1:0] memory_addr;
  logic                    memory_write_en;
  logic [`CPU4_DATA_W-1:0] memory_write_data;
  logic                    busy;
  logic                    done;
  logic                    carry;
  logic                    zero;
  logic                    decimal;
  logic                    interrupt;

  // Expected results handed to the checker with each issue
  logic                    exp_we;
  logic [`CPU4_ADDR_W-1:0] exp_addr;
  logic [`CPU4_DATA_W-1:0] exp_wdata;
  logic [3:0]              exp_flags;
  logic [2:0]              test_id;
  logic                    test_end;
  logic                    report_req;
  int                      errors;

  // Reference model state
  logic [3:0]  ma, mb, mta, mtb;
  logic [11:0] mx, my;
  logic [7:0]  msp;
  logic        mc, mz, md, mi;
  logic [3:0]  model_mem [0:4095];
  logic [3:0]  mem [0:4095];

  integer seed = 14244;
  int     cycles = 0;

  always #50 clk = ~clk;

  cpu4_datapath dut_i (
    .clk               (clk),
    .rst               (rst),
    .issue             (issue),
    .src               (src),
    .dst               (dst),
    .inc               (inc),
    .alu_op            (alu_op),
    .immed             (immed),
    .memory_addr       (memory_addr),
    .memory_write_en   (memory_write_en),
    .memory_write_data (memory_write_data),
    .memory_read_data  (memory_read_data),
    .busy              (busy),
    .done              (done),
    .carry             (carry),
    .zero              (zero),
    .decimal           (decimal),
    .interrupt         (interrupt)
  );

  tb_checker chk_i (
    .clk               (clk),
    .rst               (rst),
    .issue             (issue),
    .busy              (busy),
    .done              (done),
    .memory_addr       (memory_addr),
    .memory_write_en   (memory_write_en),
    .memory_write_data (memory_write_data),
    .carry             (carry),
    .zero              (zero),
    .decimal           (decimal),
    .interrupt         (interrupt),
    .exp_we            (exp_we),
    .exp_addr          (exp_addr),
    .exp_wdata         (exp_wdata),
    .exp_flags         (exp_flags),
    .test_id           (test_id),
    .test_end          (test_end),
    .report_req        (report_req),
    .errors            (errors)
  );

  // ------------------------------
  // Memory, read data registered
  // ------------------------------
  always @(posedge clk) begin
    if (memory_write_en === 1'b1) begin
      mem[memory_addr] <= memory_write_data;
    end
    memory_read_data <= mem[memory_addr];
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run still going after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [3:0] fill_value(input int addr);
    logic [11:0] a;
    a = 12'(addr);
    return a[3:0] ^ {a[6:4], a[7]} ^ (a[11:8] + 4'h9);
  endfunction

  function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  // Indirect field: 00 A, 01 B, 10 MX, 11 MY
  function automatic reg_type resolve_sel(input reg_type sel, input logic [7:0] imm);
    logic [1:0] f;
    case (sel)
      REG_IMM_ADDR_L: f = imm[1:0];
      REG_IMM_ADDR_H: f = imm[3:2];
      REG_IMM_ADDR_P: f = imm[5:4];
      default:        return sel;
    endcase
    case (f)
      2'd0:    return REG_A;
      2'd1:    return REG_B;
      2'd2:    return REG_MX;
      default: return REG_MY;
    endcase
  endfunction

  function automatic logic is_mem(input reg_type r);
    return (r == REG_MX) || (r == REG_MY) || (r == REG_MSP) || (r == REG_Mn);
  endfunction

  function automatic logic [11:0] operand_addr(input reg_type r, input logic [7:0] imm);
    case (r)
      REG_MX:  return mx;
      REG_MY:  return my;
      REG_MSP: return {4'h0, msp};
      REG_Mn:  return {8'h00, imm[3:0]};
      default: return 12'h000;
    endcase
  endfunction

  // Returns {carry, result}
  function automatic logic [4:0] alu_model(input alu_op_type op, input logic [3:0] a,
                                           input logic [3:0] b, input logic cin,
                                           input logic dec);
    int         s;
    logic [3:0] r;
    logic       c;
    r = b;
    c = 1'b0;
    case (op)
      ALU_ADD: begin
        s = a + b + cin;
        if (dec && s > 9) begin
          r = 4'(s + 6);
          c = 1'b1;
        end else begin
          r = 4'(s);
          c = (s > 15);
        end
      end
      ALU_SUB: begin
        s = a - b - cin;
        r = 4'(s);
        c = (s < 0);
      end
      ALU_AND: r = a & b;
      ALU_OR:  r = a | b;
      ALU_XOR: r = a ^ b;
      default: r = b;
    endcase
    return {c, r};
  endfunction

  // Predict one microinstruction, issue it and wait for done
  task automatic run_uop(input reg_type s, input reg_type d, input reg_inc_type i,
                         input alu_op_type op, input logic [7:0] imm);
    reg_type     rs;
    reg_type     rd;
    logic [3:0]  bus;
    logic [4:0]  alu_out;
    logic [11:0] old_x;
    logic [11:0] old_y;
    logic [7:0]  old_sp;
    rs = resolve_sel(s, imm);
    rd = resolve_sel(d, imm);
    alu_out = alu_model(op, mta, mtb, mc, md);
    old_x = mx;
    old_y = my;
    old_sp = msp;
    case (rs)
      REG_A:           bus = ma;
      REG_B:           bus = mb;
      REG_TEMPA:       bus = mta;
      REG_TEMPB:       bus = mtb;
      REG_XL:          bus = mx[3:0];
      REG_XH:          bus = mx[7:4];
      REG_XP:          bus = mx[11:8];
      REG_YL:          bus = my[3:0];
      REG_YH:          bus = my[7:4];
      REG_YP:          bus = my[11:8];
      REG_SPL:         bus = msp[3:0];
      REG_SPH:         bus = msp[7:4];
      REG_FLAGS:       bus = {mi, md, mz, mc};
      REG_IMML:        bus = imm[3:0];
      REG_IMMH:        bus = imm[7:4];
      REG_HARDCODED_1: bus = 4'h1;
      REG_ALU, REG_ALU_WITH_FLAGS: bus = alu_out[3:0];
      default:         bus = model_mem[operand_addr(rs, imm)];
    endcase
    if (rs == REG_ALU_WITH_FLAGS) begin
      mc = alu_out[4];
      mz = (alu_out[3:0] == 4'h0);
    end
    exp_we    = is_mem(rd);
    exp_addr  = operand_addr(rd, imm);
    exp_wdata = bus;
    case (rd)
      REG_A:     ma = bus;
      REG_B:     mb = bus;
      REG_TEMPA: mta = bus;
      REG_TEMPB: mtb = bus;
      REG_XL:    mx[3:0] = bus;
      REG_XH:    mx[7:4] = bus;
      REG_XP:    mx[11:8] = bus;
      REG_YL:    my[3:0] = bus;
      REG_YH:    my[7:4] = bus;
      REG_YP:    my[11:8] = bus;
      REG_SPL:   msp[3:0] = bus;
      REG_SPH:   msp[7:4] = bus;
      REG_FLAGS: {mi, md, mz, mc} = bus;
      default: begin
        if (is_mem(rd)) begin
          model_mem[operand_addr(rd, imm)] = bus;
        end
      end
    endcase
    // Increment from the old pointer overrides a write to it
    case (i)
      INC_X:   mx = {old_x[11:8], old_x[7:0] + 8'd1};
      INC_Y:   my = {old_y[11:8], old_y[7:0] + 8'd1};
      INC_SP:  msp = old_sp + 8'd1;
      default: ;
    endcase
    exp_flags = {mi, md, mz, mc};
    src = s;
    dst = d;
    inc = i;
    alu_op = op;
    immed = imm;
    issue = 1'b1;
    @(posedge clk);
    #1 issue = 1'b0;
    @(negedge clk);
    while (done !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input logic [2:0] next_id);
    test_end = 1'b1;
    @(posedge clk);
    #1 test_end = 1'b0;
    test_id = next_id;
  endtask

  initial begin
    reg_type r;
    reg_type s;
    rst = 1'b1;
    issue = 1'b0;
    src = REG_A;
    dst = REG_A;
    inc = INC_NONE;
    alu_op = ALU_ADD;
    immed = '0;
    memory_read_data <= '0;
    exp_we = 1'b0;
    exp_addr = '0;
    exp_wdata = '0;
    exp_flags = '0;
    test_id = 3'd0;
    test_end = 1'b0;
    report_req = 1'b0;
    {ma, mb, mta, mtb, mx, my, msp} = '0;
    {mc, mz, md, mi} = '0;
    for (int k = 0; k < 4096; k++) begin
      mem[k] <= fill_value(k);
      model_mem[k] = fill_value(k);
    end
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    finish_test(3'd1);

    // Transfers and immediates, each result stored through Mn
    repeat (12) begin
      r = reg_type'(pick(12));
      s = (pick(3) == 0) ? REG_IMML : ((pick(2) == 0) ? REG_IMMH : REG_HARDCODED_1);
      run_uop(s, r, INC_NONE, ALU_ADD, rand_byte());
      run_uop(r, REG_Mn, INC_NONE, ALU_ADD, rand_byte());
    end
    finish_test(3'd2);

    // Pointers nibble by nibble, then every memory operand
    repeat (2) begin
      for (int k = 0; k < 8; k++) begin
        run_uop(REG_IMML, reg_type'(4 + k), INC_NONE, ALU_ADD, rand_byte());
      end
      for (int k = 0; k < 4; k++) begin
        run_uop(reg_type'(18 + k), REG_A, INC_NONE, ALU_ADD, rand_byte());
        run_uop(REG_A, REG_Mn, INC_NONE, ALU_ADD, rand_byte());
      end
      for (int k = 0; k < 3; k++) begin
        run_uop(REG_B, reg_type'(18 + k), INC_NONE, ALU_ADD, rand_byte());
      end
    end
    finish_test(3'd3);

    // Low byte FF wraps and keeps the page
    for (int k = 0; k < 2; k++) begin
      run_uop(REG_IMML, reg_type'(4 + 3 * k), INC_NONE, ALU_ADD, 8'h0F);
      run_uop(REG_IMML, reg_type'(5 + 3 * k), INC_NONE, ALU_ADD, 8'h0F);
      run_uop(REG_IMML, reg_type'(6 + 3 * k), INC_NONE, ALU_ADD, rand_byte());
      run_uop(REG_A, reg_type'(18 + k), reg_inc_type'(1 + k), ALU_ADD, rand_byte());
      run_uop(REG_B, reg_type'(18 + k), INC_NONE, ALU_ADD, rand_byte());
    end
    run_uop(REG_IMML, REG_SPL, INC_NONE, ALU_ADD, 8'h0F);
    run_uop(REG_IMML, REG_SPH, INC_NONE, ALU_ADD, 8'h0F);
    run_uop(REG_A, REG_MSP, INC_SP, ALU_ADD, rand_byte());
    run_uop(REG_B, REG_MSP, INC_NONE, ALU_ADD, rand_byte());
    repeat (6) begin
      run_uop(REG_A, reg_type'(18 + pick(3)), reg_inc_type'(pick(4)), ALU_ADD, rand_byte());
    end
    run_uop(REG_IMML, REG_XL, INC_X, ALU_ADD, rand_byte());
    run_uop(REG_A, REG_MX, INC_NONE, ALU_ADD, rand_byte());
    finish_test(3'd4);

    repeat (16) begin
      run_uop(reg_type'(22 + pick(3)), reg_type'(22 + pick(3)), INC_NONE, ALU_ADD,
              rand_byte());
    end
    run_uop(REG_A, REG_Mn, INC_NONE, ALU_ADD, rand_byte());
    run_uop(REG_B, REG_Mn, INC_NONE, ALU_ADD, rand_byte());
    finish_test(3'd5);

    // Random flags give both binary and decimal mode
    repeat (16) begin
      run_uop(REG_IMML, REG_TEMPA, INC_NONE, ALU_ADD, rand_byte());
      run_uop(REG_IMML, REG_TEMPB, INC_NONE, ALU_ADD, rand_byte());
      run_uop(REG_IMML, REG_FLAGS, INC_NONE, ALU_ADD, rand_byte());
      s = (pick(2) == 0) ? REG_ALU : REG_ALU_WITH_FLAGS;
      run_uop(s, REG_A, INC_NONE, alu_op_type'(pick(6)), rand_byte());
      run_uop(REG_A, REG_Mn, INC_NONE, ALU_ADD, rand_byte());
    end
    finish_test(3'd6);

    repeat (8) begin
      s = (pick(2) == 0) ? REG_B : REG_IMML;
      r = (pick(3) == 0) ? REG_A : ((pick(2) == 0) ? REG_MX : REG_Mn);
      run_uop(s, r, INC_NONE, ALU_ADD, rand_byte());
    end
    finish_test(3'd6);

    report_req = 1'b1;
    @(negedge clk);
    #1;
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu4_defs.svh"

module tb_checker (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     issue,
  input  wire                     busy,
  input  wire                     done,
  input  wire [`CPU4_ADDR_W-1:0]  memory_addr,
  input  wire                     memory_write_en,
  input  wire [`CPU4_DATA_W-1:0]  memory_write_data,
  input  wire                     carry,
  input  wire                     zero,
  input  wire                     decimal,
  input  wire                     interrupt,
  input  wire                     exp_we,
  input  wire [`CPU4_ADDR_W-1:0]  exp_addr,
  input  wire [`CPU4_DATA_W-1:0]  exp_wdata,
  input  wire [3:0]               exp_flags,
  input  wire [2:0]               test_id,
  input  wire                     test_end,
  input  wire                     report_req,
  output int                      errors
);

  int                      checks = 0;
  int                      test_checks = 0;
  int                      test_errors = 0;
  // 0 idle, 1 fetch, 2 write, 3 first cycle after write
  int                      stage = 0;
  logic                    lat_we;
  logic [`CPU4_ADDR_W-1:0] lat_addr;
  logic [`CPU4_DATA_W-1:0] lat_wdata;
  logic [3:0]              lat_flags;

  initial errors = 0;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0:    return "reset";
      3'd1:    return "transfers and immediates";
      3'd2:    return "memory addressing and reads";
      3'd3:    return "post-increment";
      3'd4:    return "indirect immediate selectors";
      3'd5:    return "ALU and flags";
      default: return "timing";
    endcase
  endfunction

  task automatic check_val(input string name, input logic [11:0] got, input logic [11:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_true(input logic ok, input string what);
    checks++;
    test_checks++;
    if (ok !== 1'b1) begin
      errors++;
      test_errors++;
      $display("ERROR at %0t ns: %s", $time, what);
    end
  endtask

  // Sampled mid-cycle, where every DUT output is settled
  always @(negedge clk) begin
    if (rst === 1'b1) begin
      expect_true(busy === 1'b0 && done === 1'b0 && memory_write_en === 1'b0,
                  "busy, done or write strobe high during reset");
      stage = 0;
    end else begin
      if (memory_write_en === 1'b1 && done !== 1'b1) begin
        expect_true(1'b0, "memory write strobe outside the done cycle");
      end
      case (stage)
        1: expect_true(busy === 1'b1 && done === 1'b0, "busy or done wrong in the fetch cycle");
        2: begin
          expect_true(done === 1'b1 && busy === 1'b1, "done not high two cycles after issue");
          check_val("memory_write_en", 12'(memory_write_en), 12'(lat_we));
          if (lat_we) begin
            check_val("memory_addr", memory_addr, lat_addr);
            check_val("memory_write_data", 12'(memory_write_data), 12'(lat_wdata));
          end
        end
        3: begin
          expect_true(busy === 1'b0 && done === 1'b0, "busy or done still high after write");
          check_val("carry", 12'(carry), 12'(lat_flags[0]));
          check_val("zero", 12'(zero), 12'(lat_flags[1]));
          check_val("decimal", 12'(decimal), 12'(lat_flags[2]));
          check_val("interrupt", 12'(interrupt), 12'(lat_flags[3]));
        end
        default: expect_true(busy === 1'b0 && done === 1'b0, "busy or done high while idle");
      endcase
      if (issue === 1'b1 && busy === 1'b0) begin
        lat_we    = exp_we;
        lat_addr  = exp_addr;
        lat_wdata = exp_wdata;
        lat_flags = exp_flags;
        stage = 1;
      end else if (stage == 1 || stage == 2) begin
        stage = stage + 1;
      end else begin
        stage = 0;
      end
    end
    if (test_end === 1'b1) begin
      $display("Test %0d, %s: %0d checks, %0d errors", test_id, test_name(test_id),
               test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
    if (report_req === 1'b1) begin
      $display("Total: %0d checks, %0d errors", checks, errors);
    end
  end

endmodule

`default_nettype wire

// ==== cpu4_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu4_defs.svh"

module cpu4_datapath (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          issue,
  input  wire cpu4_pkg::reg_type       src,
  input  wire cpu4_pkg::reg_type       dst,
  input  wire cpu4_pkg::reg_inc_type   inc,
  input  wire cpu4_pkg::alu_op_type    alu_op,
  input  wire [`CPU4_IMM_W-1:0]        immed,
  output logic [`CPU4_ADDR_W-1:0]      memory_addr,
  output logic                         memory_write_en,
  output logic [`CPU4_DATA_W-1:0]      memory_write_data,
  input  wire [`CPU4_DATA_W-1:0]       memory_read_data,
  output logic                         busy,
  output logic                         done,
  output logic                         carry,
  output logic                         zero,
  output logic                         decimal,
  output logic                         interrupt
);
  import cpu4_pkg::*;

  microcode_cycle          current_cycle;
  reg_type                 cur_src;
  reg_type                 cur_dst;
  reg_inc_type             cur_inc;
  alu_op_type              cur_alu_op;
  logic [`CPU4_IMM_W-1:0]  cur_immed;
  logic [`CPU4_DATA_W-1:0] temp_a;
  logic [`CPU4_DATA_W-1:0] temp_b;
  logic [`CPU4_DATA_W-1:0] alu_result;
  logic                    alu_zero;
  logic                    alu_carry;

  micro_sequencer seq_i (
    .clk           (clk),
    .rst           (rst),
    .issue         (issue),
    .src           (src),
    .dst           (dst),
    .inc           (inc),
    .alu_op        (alu_op),
    .immed         (immed),
    .current_cycle (current_cycle),
    .cur_src       (cur_src),
    .cur_dst       (cur_dst),
    .cur_inc       (cur_inc),
    .cur_alu_op    (cur_alu_op),
    .cur_immed     (cur_immed),
    .busy          (busy),
    .done          (done)
  );

  regs regs_i (
    .clk                 (clk),
    .rst                 (rst),
    .current_cycle       (current_cycle),
    .bus_input_selector  (cur_src),
    .bus_output_selector (cur_dst),
    .increment_selector  (cur_inc),
    .immed               (cur_immed),
    .alu                 (alu_result),
    .alu_zero            (alu_zero),
    .alu_carry           (alu_carry),
    .memory_read_data    (memory_read_data),
    .memory_addr         (memory_addr),
    .memory_write_en     (memory_write_en),
    .memory_write_data   (memory_write_data),
    .temp_a              (temp_a),
    .temp_b              (temp_b),
    .carry               (carry),
    .zero                (zero),
    .decimal             (decimal),
    .interrupt           (interrupt)
  );

  // Carry flag feeds back as carry in
  alu alu_i (
    .temp_a   (temp_a),
    .temp_b   (temp_b),
    .op       (cur_alu_op),
    .carry_in (carry),
    .decimal  (decimal),
    .result   (alu_result),
    .zero     (alu_zero),
    .carry    (alu_carry)
  );

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu4_defs.svh"

module alu (
  input  wire [`CPU4_DATA_W-1:0]     temp_a,
  input  wire [`CPU4_DATA_W-1:0]     temp_b,
  input  wire cpu4_pkg::alu_op_type  op,
  input  wire                        carry_in,
  input  wire                        decimal,
  output logic [`CPU4_DATA_W-1:0]    result,
  output logic                       zero,
  output logic                       carry
);
  import cpu4_pkg::*;

  // One extra bit for carry out and borrow
  logic [`CPU4_DATA_W:0] sum;
  logic [`CPU4_DATA_W:0] diff;

  assign sum  = {1'b0, temp_a} + {1'b0, temp_b} + {{`CPU4_DATA_W{1'b0}}, carry_in};
  assign diff = {1'b0, temp_a} - {1'b0, temp_b} - {{`CPU4_DATA_W{1'b0}}, carry_in};

  always_comb begin
    result = temp_b;
    carry  = 1'b0;
    case (op)
      ALU_ADD: begin
        if (decimal && (sum > 'd9)) begin
          // BCD adjust, wraps to one digit
          result = sum[`CPU4_DATA_W-1:0] + 4'd6;
          carry  = 1'b1;
        end else begin
          result = sum[`CPU4_DATA_W-1:0];
          carry  = sum[`CPU4_DATA_W];
        end
      end
      ALU_SUB: begin
        result = diff[`CPU4_DATA_W-1:0];
        carry  = diff[`CPU4_DATA_W];
      end
      ALU_AND: result = temp_a & temp_b;
      ALU_OR:  result = temp_a | temp_b;
      ALU_XOR: result = temp_a ^ temp_b;
      ALU_PASS: result = temp_b;
      default: result = temp_b;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu4_defs.svh"

module regs (
  input  wire                            clk,
  input  wire                            rst,
  input  wire cpu4_pkg::microcode_cycle  current_cycle,
  input  wire cpu4_pkg::reg_type         bus_input_selector,
  input  wire cpu4_pkg::reg_type         bus_output_selector,
  input  wire cpu4_pkg::reg_inc_type     increment_selector,
  input  wire [`CPU4_IMM_W-1:0]          immed,
  input  wire [`CPU4_DATA_W-1:0]         alu,
  input  wire                            alu_zero,
  input  wire                            alu_carry,
  input  wire [`CPU4_DATA_W-1:0]         memory_read_data,
  output logic [`CPU4_ADDR_W-1:0]        memory_addr,
  output logic                           memory_write_en,
  output logic [`CPU4_DATA_W-1:0]        memory_write_data,
  output logic [`CPU4_DATA_W-1:0]        temp_a,
  output logic [`CPU4_DATA_W-1:0]        temp_b,
  output logic                           carry,
  output logic                           zero,
  output logic                           decimal,
  output logic                           interrupt
);
  import cpu4_pkg::*;

  logic [`CPU4_DATA_W-1:0] a;
  logic [`CPU4_DATA_W-1:0] b;
  logic [`CPU4_ADDR_W-1:0] x;
  logic [`CPU4_ADDR_W-1:0] y;
  logic [`CPU4_SP_W-1:0]   sp;

  reg_type                 src_r;
  reg_type                 dst_r;
  reg_type                 addr_op;
  logic [`CPU4_DATA_W-1:0] bus;
  logic                    src_mem;
  logic                    dst_mem;
  logic                    write_phase;

  // Map an indirect selector to A, B, MX or MY
  function automatic reg_type resolve(input reg_type sel,
                                      input logic [`CPU4_IMM_W-1:0] imm);
    logic [`CPU4_SEL_W-1:0] field;
    reg_type                picked;
    case (sel)
      REG_IMM_ADDR_L: field = imm[`CPU4_SEL_L_LSB +: `CPU4_SEL_W];
      REG_IMM_ADDR_H: field = imm[`CPU4_SEL_H_LSB +: `CPU4_SEL_W];
      default:        field = imm[`CPU4_SEL_P_LSB +: `CPU4_SEL_W];
    endcase
    case (field)
      2'b00:   picked = REG_A;
      2'b01:   picked = REG_B;
      2'b10:   picked = REG_MX;
      default: picked = REG_MY;
    endcase
    if (sel inside {REG_IMM_ADDR_L, REG_IMM_ADDR_H, REG_IMM_ADDR_P}) begin
      return picked;
    end
    return sel;
  endfunction

  function automatic logic is_mem(input reg_type r);
    return r inside {REG_MX, REG_MY, REG_MSP, REG_Mn};
  endfunction

  assign src_r       = resolve(bus_input_selector, immed);
  assign dst_r       = resolve(bus_output_selector, immed);
  assign src_mem     = is_mem(src_r);
  assign dst_mem     = is_mem(dst_r);
  assign write_phase = (current_cycle == CYCLE_REG_WRITE);

  // ------------------------------
  // Memory addressing
  // ------------------------------
  always_comb begin
    // Fetch reads the source, write strobes the destination
    if (write_phase && dst_mem) begin
      addr_op = dst_r;
    end else if (src_mem) begin
      addr_op = src_r;
    end else begin
      addr_op = dst_r;
    end
    case (addr_op)
      REG_MX:  memory_addr = x;
      REG_MY:  memory_addr = y;
      REG_MSP: memory_addr = {{(`CPU4_ADDR_W-`CPU4_SP_W){1'b0}}, sp};
      REG_Mn:  memory_addr = {{(`CPU4_ADDR_W-`CPU4_DATA_W){1'b0}}, immed[`CPU4_DATA_W-1:0]};
      default: memory_addr = '0;
    endcase
  end

  // ------------------------------
  // Bus source
  // ------------------------------
  always_comb begin
    case (src_r)
      REG_A:              bus = a;
      REG_B:              bus = b;
      REG_TEMPA:          bus = temp_a;
      REG_TEMPB:          bus = temp_b;
      REG_XL:             bus = x[3:0];
      REG_XH:             bus = x[7:4];
      REG_XP:             bus = x[11:8];
      REG_YL:             bus = y[3:0];
      REG_YH:             bus = y[7:4];
      REG_YP:             bus = y[11:8];
      REG_SPL:            bus = sp[3:0];
      REG_SPH:            bus = sp[7:4];
      REG_FLAGS:          bus = {interrupt, decimal, zero, carry};
      REG_ALU,
      REG_ALU_WITH_FLAGS: bus = alu;
      REG_IMML:           bus = immed[3:0];
      REG_IMMH:           bus = immed[7:4];
      REG_HARDCODED_1:    bus = 4'h1;
      REG_MX,
      REG_MY,
      REG_MSP,
      REG_Mn:             bus = memory_read_data;
      default:            bus = '0;
    endcase
  end

  assign memory_write_data = bus;
  assign memory_write_en   = write_phase && dst_mem;

  // ------------------------------
  // Register update at end of write
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      a         <= '0;
      b         <= '0;
      temp_a    <= '0;
      temp_b    <= '0;
      x         <= '0;
      y         <= '0;
      sp        <= '0;
      carry     <= 1'b0;
      zero      <= 1'b0;
      decimal   <= 1'b0;
      interrupt <= 1'b0;
    end else if (write_phase) begin
      if (src_r == REG_ALU_WITH_FLAGS) begin
        zero  <= alu_zero;
        carry <= alu_carry;
      end
      case (dst_r)
        REG_A:     a <= bus;
        REG_B:     b <= bus;
        REG_TEMPA: temp_a <= bus;
        REG_TEMPB: temp_b <= bus;
        REG_XL:    x[3:0] <= bus;
        REG_XH:    x[7:4] <= bus;
        REG_XP:    x[11:8] <= bus;
        REG_YL:    y[3:0] <= bus;
        REG_YH:    y[7:4] <= bus;
        REG_YP:    y[11:8] <= bus;
        REG_SPL:   sp[3:0] <= bus;
        REG_SPH:   sp[7:4] <= bus;
        REG_FLAGS: {interrupt, decimal, zero, carry} <= bus;
        default:   ;
      endcase
      // Placed last so it overrides a write to the same pointer
      case (increment_selector)
        INC_X: begin
          x <= {x[`CPU4_ADDR_W-1:`CPU4_PTR_LO_W], x[`CPU4_PTR_LO_W-1:0] + 1'b1};
        end
        INC_Y: begin
          y <= {y[`CPU4_ADDR_W-1:`CPU4_PTR_LO_W], y[`CPU4_PTR_LO_W-1:0] + 1'b1};
        end
        INC_SP:  sp <= sp + 1'b1;
        default: ;
      endcase
    end
  end

  // Strobe lasts a single write phase
  a_write_en_pulse : assert property (@(posedge clk) disable iff (rst)
    memory_write_en |=> !memory_write_en)
    else $error("memory write strobe held past the write phase");

endmodule

`default_nettype wire

// ==== micro_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu4_defs.svh"

module micro_sequencer (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          issue,
  input  wire cpu4_pkg::reg_type       src,
  input  wire cpu4_pkg::reg_type       dst,
  input  wire cpu4_pkg::reg_inc_type   inc,
  input  wire cpu4_pkg::alu_op_type    alu_op,
  input  wire [`CPU4_IMM_W-1:0]        immed,
  output cpu4_pkg::microcode_cycle     current_cycle,
  output cpu4_pkg::reg_type            cur_src,
  output cpu4_pkg::reg_type            cur_dst,
  output cpu4_pkg::reg_inc_type        cur_inc,
  output cpu4_pkg::alu_op_type         cur_alu_op,
  output logic [`CPU4_IMM_W-1:0]       cur_immed,
  output logic                         busy,
  output logic                         done
);
  import cpu4_pkg::*;

  logic accept;

  assign accept = issue && !busy;

  // ------------------------------
  // Phase FSM
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      current_cycle <= CYCLE_NONE;
      cur_src       <= REG_A;
      cur_dst       <= REG_A;
      cur_inc       <= INC_NONE;
      cur_alu_op    <= ALU_ADD;
    end else begin
      case (current_cycle)
        CYCLE_NONE: begin
          if (accept) begin
            current_cycle <= CYCLE_REG_FETCH;
            cur_src       <= src;
            cur_dst       <= dst;
            cur_inc       <= inc;
            cur_alu_op    <= alu_op;
          end
        end
        CYCLE_REG_FETCH: current_cycle <= CYCLE_REG_WRITE;
        CYCLE_REG_WRITE: current_cycle <= CYCLE_NONE;
        default:         current_cycle <= CYCLE_NONE;
      endcase
    end
  end

  // Immediate held for both phases
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_immed <= immed;
    end
  end

  assign busy = (current_cycle != CYCLE_NONE);
  assign done = (current_cycle == CYCLE_REG_WRITE);

  // ------------------------------
  // Checks
  // ------------------------------
  // Controller must wait for busy to drop
  a_issue_while_busy : assert property (@(posedge clk) disable iff (rst)
    busy |-> !issue)
    else $error("microinstruction issued while busy");

  a_write_after_fetch : assert property (@(posedge clk) disable iff (rst)
    (current_cycle == CYCLE_REG_WRITE) |-> ($past(current_cycle) == CYCLE_REG_FETCH))
    else $error("write phase without a preceding fetch");

endmodule

`default_nettype wire

// ==== cpu4_pkg.sv ====
`default_nettype none

package cpu4_pkg;

  // Bus source and destination selector
  typedef enum logic [4:0] {
    REG_A,
    REG_B,
    REG_TEMPA,
    REG_TEMPB,
    REG_XL,
    REG_XH,
    REG_XP,
    REG_YL,
    REG_YH,
    REG_YP,
    REG_SPL,
    REG_SPH,
    REG_FLAGS,
    // Source only
    REG_ALU,
    REG_ALU_WITH_FLAGS,
    REG_IMML,
    REG_IMMH,
    REG_HARDCODED_1,
    // Memory operands
    REG_MX,
    REG_MY,
    REG_MSP,
    REG_Mn,
    // Picked by a 2-bit immediate field
    REG_IMM_ADDR_L,
    REG_IMM_ADDR_H,
    REG_IMM_ADDR_P
  } reg_type;

  typedef enum logic [1:0] {
    INC_NONE,
    INC_X,
    INC_Y,
    INC_SP
  } reg_inc_type;

  typedef enum logic [1:0] {
    CYCLE_NONE,
    CYCLE_REG_FETCH,
    CYCLE_REG_WRITE
  } microcode_cycle;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS
  } alu_op_type;

endpackage

`default_nettype wire

// ==== cpu4_defs.svh ====
`ifndef CPU4_DEFS_SVH
`define CPU4_DEFS_SVH

// Datapath widths
`define CPU4_DATA_W 4
`define CPU4_ADDR_W 12
`define CPU4_SP_W 8
`define CPU4_IMM_W 8

// Low byte of X and Y, the part that post-increment wraps in
`define CPU4_PTR_LO_W 8

// ------------------------------
// Indirect selector fields in the immediate
// ------------------------------
`define CPU4_SEL_W 2
`define CPU4_SEL_L_LSB 0
`define CPU4_SEL_H_LSB 2
`define CPU4_SEL_P_LSB 4

`endif
